/* dv/tb_exec_top.sv */
module tb_exec_top;

  localparam int n_rand = 40; // random instructions per phase.
  localparam int n_inst = 192 + 4 * n_rand;
  localparam int max_cycles = n_inst * 80 + 200;

  typedef struct packed {
    exec_pkg::retire_t rec;
    logic flags_only; // only the flags are defined for illegal encodings.
    logic [7:0] min_lat;
  } expect_t;

  logic clk;
  logic rst;
  logic inst_valid;
  logic inst_ready;
  logic [31:0] inst;
  logic res_valid;
  logic res_ready;
  exec_pkg::retire_t res;
  logic bp_en;
  logic busy;
  logic res_seen = 1'b0;
  int errors = 0;
  int sent = 0;
  int retired = 0;
  longint cyc = 0;
  longint accept_cyc = 0;
  logic [63:0] model [32];
  expect_t exp_q [$];

  exec_top uut (
    .clk(clk),
    .rst(rst),
    .inst_valid(inst_valid),
    .inst_ready(inst_ready),
    .inst(inst),
    .res_valid(res_valid),
    .res_ready(res_ready),
    .res(res)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (max_cycles) @(posedge clk);
    $display("timeout: no finish within %0d cycles, %0d errors", max_cycles, errors);
    $display("Simulation failed");
    $finish;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // random stalls only while back-pressure is enabled.
  always @(posedge clk) begin
    #2;
    res_ready = bp_en ? ($urandom_range(0, 2) != 0) : 1'b1;
  end

  // an instruction is in flight from its accept to its result handshake.
  always @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (inst_valid && inst_ready) begin
      busy <= 1'b1;
    end else if (res_valid && res_ready) begin
      busy <= 1'b0;
    end
  end

  // a stalled result must hold.
  assert property (@(posedge clk) disable iff (rst)
    res_valid && !res_ready |=> res_valid && $stable(res))
    else begin
      errors++;
      $display("result changed or was dropped while res_ready was low");
    end

  assert property (@(posedge clk) disable iff (rst) busy |-> !inst_ready)
    else begin
      errors++;
      $display("inst_ready was high while an instruction was in flight");
    end

  assert property (@(posedge clk) disable iff (rst) res_valid && res_ready |=> inst_ready)
    else begin
      errors++;
      $display("inst_ready did not return after the result handshake");
    end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] want);
    assert (got === want) else begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, want);
    end
  endtask

  always @(posedge clk) begin
    expect_t e;
    if (!rst) begin
      if (inst_valid && inst_ready) begin
        accept_cyc <= cyc;
        res_seen <= 1'b0;
      end
      if (res_valid && !res_seen && exp_q.size() > 0) begin
        res_seen <= 1'b1; // first cycle of this result.
        assert (cyc - accept_cyc >= longint'(exp_q[0].min_lat)) else begin
          errors++;
          $display("result came %0d cycles after accept, minimum is %0d",
                   cyc - accept_cyc, exp_q[0].min_lat);
        end
      end
      if (res_valid && res_ready) begin
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("a result retired with no instruction outstanding");
        end
        if (exp_q.size() > 0) begin
          e = exp_q.pop_front();
          retired++;
          check_eq("res.illegal", 64'(res.illegal), 64'(e.rec.illegal));
          check_eq("res.writes_rd", 64'(res.writes_rd), 64'(e.rec.writes_rd));
          if (!e.flags_only) begin
            check_eq("res.rd", 64'(res.rd), 64'(e.rec.rd));
            check_eq("res.value", res.value, e.rec.value);
          end
        end
      end
    end
  end

  // rv64i result for a funct3 code and the alternate funct7 bit.
  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[5:0];
      3'd2: return {63'b0, $signed(a) < $signed(b)};
      3'd3: return {63'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[5:0]) : a >> b[5:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic expect_t make_exp(input logic [4:0] rd, input logic [63:0] value,
                                       input int lat);
    expect_t e;
    e.rec.rd = rd;
    e.rec.value = value;
    e.rec.writes_rd = 1'b1;
    e.rec.illegal = 1'b0;
    e.flags_only = 1'b0;
    e.min_lat = 8'(lat);
    return e;
  endfunction

  function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [4:0] rnd_reg();
    return 5'($urandom_range(1, 31));
  endfunction

  // one of the non-shift funct3 codes 0, 2, 3, 4, 6, 7.
  function automatic logic [2:0] pick_f3();
    int k;
    k = $urandom_range(0, 5);
    return (k == 0) ? 3'd0 : (k < 4) ? 3'(k + 1) : 3'(k + 2);
  endfunction

  task automatic issue(input logic [31:0] word, input expect_t e);
    if (!e.rec.illegal && e.rec.writes_rd && e.rec.rd != 0) begin
      model[e.rec.rd] = e.rec.value;
    end
    sent++;
    inst = word;
    inst_valid = 1'b1;
    do begin
      @(posedge clk);
    end while (!inst_ready);
    exp_q.push_back(e); // outstanding from the accepting edge on.
    #2;
    inst_valid = 1'b0;
  endtask

  task automatic reg_op(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
    int lat;
    lat = (f3 == 3'd1 || f3 == 3'd5) ? 3 + model[rs2][5:0] : 3;
    issue(enc_r(alt, rs2, rs1, f3, rd),
          make_exp(rd, alu_ref(f3, alt, model[rs1], model[rs2]), lat));
  endtask

  task automatic imm_op(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
    logic alt;
    int lat;
    alt = (f3 == 3'd5) && imm[10]; // srai.
    lat = (f3 == 3'd1 || f3 == 3'd5) ? 3 + imm[5:0] : 3;
    issue(enc_i(imm, rs1, f3, rd),
          make_exp(rd, alu_ref(f3, alt, model[rs1], {{52{imm[11]}}, imm}), lat));
  endtask

  task automatic lui_op(input logic [4:0] rd, input logic [19:0] imm);
    issue({imm, rd, 7'b0110111}, make_exp(rd, {{32{imm[19]}}, imm, 12'b0}, 3));
  endtask

  task automatic bad_op(input logic [31:0] word);
    expect_t e;
    e = make_exp(5'd0, 64'd0, 3);
    e.rec.writes_rd = 1'b0;
    e.rec.illegal = 1'b1;
    e.flags_only = 1'b1;
    issue(word, e);
  endtask

  task automatic rand_shift();
    logic [2:0] f3;
    logic alt;
    f3 = ($urandom_range(0, 1) == 0) ? 3'd1 : 3'd5;
    alt = (f3 == 3'd5) && ($urandom_range(0, 1) == 1);
    if ($urandom_range(0, 1) == 0) begin
      imm_op(f3, rnd_reg(), rnd_reg(), {1'b0, alt, 4'b0, 6'($urandom)});
    end else begin
      reg_op(f3, alt, rnd_reg(), rnd_reg(), rnd_reg());
    end
  endtask

  task automatic rand_alu();
    case ($urandom_range(0, 3))
      0: lui_op(rnd_reg(), 20'($urandom));
      1: imm_op(pick_f3(), rnd_reg(), rnd_reg(), 12'($urandom));
      2: reg_op(3'd0, 1'b1, rnd_reg(), rnd_reg(), rnd_reg()); // sub.
      default: reg_op(pick_f3(), 1'b0, rnd_reg(), rnd_reg(), rnd_reg());
    endcase
  endtask

  task automatic read_back_all();
    for (int r = 0; r < 32; r++) begin
      imm_op(3'd0, 5'(r), 5'(r), 12'h000);
    end
  endtask

  initial begin
    logic [5:0] amt;
    void'($urandom(32'h8717_a1fd));
    rst = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    res_ready = 1'b0;
    bp_en = 1'b0;
    for (int r = 0; r < 32; r++) begin
      model[r] = rv_isa_pkg::regs_init;
    end
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    assert (!res_valid && inst_ready) else begin
      errors++;
      $display("handshake outputs wrong after reset");
    end
    read_back_all();
    // fill every register with wide values that include negatives.
    for (int r = 1; r < 32; r++) begin
      lui_op(5'(r), 20'($urandom));
      imm_op(3'd0, 5'(r), 5'(r), 12'($urandom));
      imm_op(3'd1, 5'(r), 5'(r), {6'b0, 6'($urandom_range(0, 32))});
    end
    repeat (n_rand) imm_op(pick_f3(), rnd_reg(), rnd_reg(), 12'($urandom));
    repeat (n_rand) rand_alu();
    for (int i = 0; i < 3; i++) begin
      amt = (i == 0) ? 6'd0 : (i == 1) ? 6'd1 : 6'd63;
      imm_op(3'd1, rnd_reg(), rnd_reg(), {6'b000000, amt});
      imm_op(3'd5, rnd_reg(), rnd_reg(), {6'b000000, amt});
      imm_op(3'd5, rnd_reg(), rnd_reg(), {6'b010000, amt});
      imm_op(3'd0, 5'd31, 5'd0, {1'b0, 5'($urandom), amt}); // upper bits are ignored.
      reg_op(3'd1, 1'b0, 5'($urandom_range(1, 30)), rnd_reg(), 5'd31);
      reg_op(3'd5, 1'b0, 5'($urandom_range(1, 30)), rnd_reg(), 5'd31);
      reg_op(3'd5, 1'b1, 5'($urandom_range(1, 30)), rnd_reg(), 5'd31);
    end
    repeat (n_rand) rand_shift();
    repeat (2) begin
      imm_op(pick_f3(), 5'd0, rnd_reg(), 12'($urandom));
      imm_op(3'd0, rnd_reg(), 5'd0, 12'h000);
      reg_op(pick_f3(), 1'b0, 5'd0, rnd_reg(), rnd_reg());
      imm_op(3'd0, rnd_reg(), 5'd0, 12'h000);
    end
    bad_op({12'h010, 5'd2, 3'b011, 5'd3, 7'b0000011}); // ld.
    bad_op(enc_r(1'b0, 5'd4, 5'd5, 3'd0, 5'd6) | 32'h0200_0000); // mul.
    bad_op(enc_r(1'b1, 5'd7, 5'd8, 3'd7, 5'd9));
    bad_op(enc_i({6'b010000, 6'd3}, 5'd10, 3'd1, 5'd11));
    bad_op(enc_i({6'b000001, 6'd5}, 5'd12, 3'd5, 5'd13));
    bad_op({7'b0, 5'd14, 5'd15, 3'd0, 5'd16, 7'b0111011}); // addw.
    read_back_all();
    bp_en = 1'b1;
    repeat (n_rand) begin
      if ($urandom_range(0, 2) == 0) begin
        rand_shift();
      end else begin
        rand_alu();
      end
    end
    while (exp_q.size() > 0) @(posedge clk);
    bp_en = 1'b0;
    repeat (10) @(posedge clk);
    $display("run done: %0d sent, %0d retired, %0d errors", sent, retired, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* hw/exec_ctrl.sv */
module exec_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic inst_valid,
  output logic inst_ready,
  input  logic [rv_isa_pkg::inst_w-1:0] inst,
  output logic res_valid,
  input  logic res_ready,
  output exec_pkg::retire_t res,
  output logic [rv_isa_pkg::inst_w-1:0] inst_word,
  input  exec_pkg::decoded_t dec,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs2_addr,
  output logic wr_en,
  output logic [rv_isa_pkg::reg_addr_w-1:0] wr_addr,
  output logic [rv_isa_pkg::xlen-1:0] wr_data,
  output logic load_operands,
  output logic do_exec,
  output logic shift_step,
  output logic cnt_load,
  output logic [rv_isa_pkg::shamt_w-1:0] shamt,
  input  logic cnt_done,
  input  logic [rv_isa_pkg::xlen-1:0] result
);

  exec_pkg::state_e state;
  exec_pkg::state_e state_nxt;
  logic is_shift;
  logic inst_fire;
  logic res_fire;

  assign is_shift = dec.alu_op inside {rv_isa_pkg::sll, rv_isa_pkg::srl, rv_isa_pkg::sra};
  assign inst_fire = inst_valid && inst_ready;
  assign res_fire = res_valid && res_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= exec_pkg::idle;
    end else begin
      state <= state_nxt;
    end
  end

  // the word stays put until the next accept, which keeps dec and res stable.
  always_ff @(posedge clk) begin
    if (inst_fire) begin
      inst_word <= inst;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      exec_pkg::idle: begin
        if (inst_valid) begin
          state_nxt = exec_pkg::read;
        end
      end
      exec_pkg::read: state_nxt = exec_pkg::exec;
      exec_pkg::exec: state_nxt = is_shift ? exec_pkg::shift : exec_pkg::retire;
      exec_pkg::shift: begin
        if (cnt_done) begin
          state_nxt = exec_pkg::retire;
        end
      end
      exec_pkg::retire: begin
        if (res_ready) begin
          state_nxt = exec_pkg::idle;
        end
      end
      default: state_nxt = exec_pkg::idle;
    endcase
  end

  assign inst_ready = (state == exec_pkg::idle);
  assign res_valid = (state == exec_pkg::retire);

  // both sources are read every instruction.
  assign rs1_addr = dec.rs1;
  assign rs2_addr = dec.rs2;

  assign load_operands = (state == exec_pkg::read);
  assign do_exec = (state == exec_pkg::exec);
  assign cnt_load = do_exec && is_shift;
  assign shamt = result[rv_isa_pkg::shamt_w-1:0]; // operand b sits in result during exec.
  assign shift_step = (state == exec_pkg::shift) && !cnt_done;

  always_comb begin
    res.rd = dec.rd;
    res.value = result;
    res.writes_rd = dec.writes_rd;
    res.illegal = dec.illegal;
  end

  // write back only on the retire handshake.
  assign wr_en = res_fire && dec.writes_rd && !dec.illegal;
  assign wr_addr = dec.rd;
  assign wr_data = result;

endmodule

/* hw/exec_pkg.sv */
package exec_pkg;

  // controller states.
  typedef enum logic [2:0] {
    idle   = 3'd0,
    read   = 3'd1,
    exec   = 3'd2,
    shift  = 3'd3,
    retire = 3'd4
  } state_e;

  // one decoded instruction.
  typedef struct packed {
    rv_isa_pkg::alu_op_e alu_op;
    logic [rv_isa_pkg::reg_addr_w-1:0] rd;
    logic [rv_isa_pkg::reg_addr_w-1:0] rs1;
    logic [rv_isa_pkg::reg_addr_w-1:0] rs2;
    logic [rv_isa_pkg::xlen-1:0] imm; // sign-extended, or the lui value.
    logic use_imm; // operand b comes from imm instead of rs2.
    logic writes_rd;
    logic illegal;
  } decoded_t;

  // record reported on the result stream.
  typedef struct packed {
    logic [rv_isa_pkg::reg_addr_w-1:0] rd;
    logic [rv_isa_pkg::xlen-1:0] value;
    logic writes_rd;
    logic illegal;
  } retire_t;

endpackage

/* hw/exec_top.sv */
module exec_top #(
  parameter int num_regs = 32
) (
  input  logic clk,
  input  logic rst,
  input  logic inst_valid,
  output logic inst_ready,
  input  logic [rv_isa_pkg::inst_w-1:0] inst,
  output logic res_valid,
  input  logic res_ready,
  output exec_pkg::retire_t res
);

  logic [rv_isa_pkg::inst_w-1:0] inst_word;
  exec_pkg::decoded_t dec;
  logic [rv_isa_pkg::reg_addr_w-1:0] rs1_addr;
  logic [rv_isa_pkg::reg_addr_w-1:0] rs2_addr;
  logic [rv_isa_pkg::xlen-1:0] rs1_data;
  logic [rv_isa_pkg::xlen-1:0] rs2_data;
  logic wr_en;
  logic [rv_isa_pkg::reg_addr_w-1:0] wr_addr;
  logic [rv_isa_pkg::xlen-1:0] wr_data;
  logic load_operands;
  logic do_exec;
  logic shift_step;
  logic cnt_load;
  logic [rv_isa_pkg::shamt_w-1:0] shamt;
  logic cnt_done;
  logic [rv_isa_pkg::xlen-1:0] result;

  exec_ctrl u_ctrl (
    .clk(clk),
    .rst(rst),
    .inst_valid(inst_valid),
    .inst_ready(inst_ready),
    .inst(inst),
    .res_valid(res_valid),
    .res_ready(res_ready),
    .res(res),
    .inst_word(inst_word),
    .dec(dec),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .load_operands(load_operands),
    .do_exec(do_exec),
    .shift_step(shift_step),
    .cnt_load(cnt_load),
    .shamt(shamt),
    .cnt_done(cnt_done),
    .result(result)
  );

  inst_decoder u_dec (
    .inst(inst_word),
    .dec(dec)
  );

  reg_file #(.num_regs(num_regs)) u_rf (
    .clk(clk),
    .rst(rst),
    .rd1_addr(rs1_addr),
    .rd2_addr(rs2_addr),
    .rd1_data(rs1_data),
    .rd2_data(rs2_data),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data)
  );

  execute_unit u_exu (
    .clk(clk),
    .rst(rst),
    .dec(dec),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .load_operands(load_operands),
    .do_exec(do_exec),
    .shift_step(shift_step),
    .result(result)
  );

  shift_counter u_cnt (
    .clk(clk),
    .rst(rst),
    .load(cnt_load),
    .shamt(shamt),
    .done(cnt_done)
  );

endmodule

/* hw/execute_unit.sv */
module execute_unit (
  input  logic clk,
  input  logic rst,
  input  exec_pkg::decoded_t dec,
  input  logic [rv_isa_pkg::xlen-1:0] rs1_data,
  input  logic [rv_isa_pkg::xlen-1:0] rs2_data,
  input  logic load_operands,
  input  logic do_exec,
  input  logic shift_step,
  output logic [rv_isa_pkg::xlen-1:0] result
);

  logic [rv_isa_pkg::xlen-1:0] op_a;
  logic [rv_isa_pkg::xlen-1:0] op_b;
  logic [rv_isa_pkg::xlen-1:0] alu_out;
  logic [rv_isa_pkg::xlen-1:0] b_sel;

  assign b_sel = dec.use_imm ? dec.imm : rs2_data;

  always_comb begin
    alu_out = '0;
    case (dec.alu_op)
      rv_isa_pkg::add:    alu_out = op_a + op_b;
      rv_isa_pkg::sub:    alu_out = op_a - op_b;
      rv_isa_pkg::and_op: alu_out = op_a & op_b;
      rv_isa_pkg::or_op:  alu_out = op_a | op_b;
      rv_isa_pkg::xor_op: alu_out = op_a ^ op_b;
      rv_isa_pkg::slt:    alu_out[0] = $signed(op_a) < $signed(op_b);
      rv_isa_pkg::sltu:   alu_out[0] = op_a < op_b;
      rv_isa_pkg::pass_b: alu_out = op_b;
      default:            alu_out = op_a; // shifts start from rs1 and step from there.
    endcase
  end

  always_ff @(posedge clk) begin
    if (load_operands) begin
      op_a <= rs1_data;
      op_b <= b_sel;
    end
  end

  // result also holds operand b for one cycle so the controller can read the shift amount.
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (load_operands) begin
      result <= b_sel;
    end else if (do_exec) begin
      result <= alu_out;
    end else if (shift_step) begin
      case (dec.alu_op)
        rv_isa_pkg::sll: result <= {result[rv_isa_pkg::xlen-2:0], 1'b0};
        rv_isa_pkg::sra: result <= {result[rv_isa_pkg::xlen-1], result[rv_isa_pkg::xlen-1:1]};
        default:         result <= {1'b0, result[rv_isa_pkg::xlen-1:1]};
      endcase
    end
  end

endmodule

/* hw/inst_decoder.sv */
module inst_decoder (
  input  logic [rv_isa_pkg::inst_w-1:0] inst,
  output exec_pkg::decoded_t dec
);

  rv_isa_pkg::opcode_e opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6;
  logic [rv_isa_pkg::xlen-1:0] imm_i;
  logic [rv_isa_pkg::xlen-1:0] imm_u;
  logic bad;

  assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign funct6 = inst[31:26]; // rv64 immediate shifts take bit 25 as shamt[5].

  // i-type and u-type immediates, both sign-extended to xlen.
  assign imm_i = {{(rv_isa_pkg::xlen-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(rv_isa_pkg::xlen-32){inst[31]}}, inst[31:12], 12'b0};

  always_comb begin
    dec = '0;
    dec.rd = inst[11:7];
    dec.rs1 = inst[19:15];
    dec.rs2 = inst[24:20];
    dec.imm = imm_i;
    dec.alu_op = rv_isa_pkg::add;
    dec.writes_rd = 1'b1;
    bad = 1'b0;
    case (opcode)
      rv_isa_pkg::opc_op: begin
        case (funct3)
          3'b000: dec.alu_op = funct7[5] ? rv_isa_pkg::sub : rv_isa_pkg::add;
          3'b001: dec.alu_op = rv_isa_pkg::sll;
          3'b010: dec.alu_op = rv_isa_pkg::slt;
          3'b011: dec.alu_op = rv_isa_pkg::sltu;
          3'b100: dec.alu_op = rv_isa_pkg::xor_op;
          3'b101: dec.alu_op = funct7[5] ? rv_isa_pkg::sra : rv_isa_pkg::srl;
          3'b110: dec.alu_op = rv_isa_pkg::or_op;
          default: dec.alu_op = rv_isa_pkg::and_op;
        endcase
        // only add/sub and srl/sra have an alternate funct7.
        if (funct7 == rv_isa_pkg::f7_alt) begin
          bad = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          bad = (funct7 != rv_isa_pkg::f7_base);
        end
      end
      rv_isa_pkg::opc_op_imm: begin
        dec.use_imm = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = rv_isa_pkg::add;
          3'b010: dec.alu_op = rv_isa_pkg::slt;
          3'b011: dec.alu_op = rv_isa_pkg::sltu;
          3'b100: dec.alu_op = rv_isa_pkg::xor_op;
          3'b110: dec.alu_op = rv_isa_pkg::or_op;
          3'b111: dec.alu_op = rv_isa_pkg::and_op;
          3'b001: begin
            dec.alu_op = rv_isa_pkg::sll;
            bad = (funct6 != rv_isa_pkg::f6_base);
          end
          default: begin
            dec.alu_op = funct6[4] ? rv_isa_pkg::sra : rv_isa_pkg::srl;
            bad = (funct6 != rv_isa_pkg::f6_base) && (funct6 != rv_isa_pkg::f6_alt);
          end
        endcase
      end
      rv_isa_pkg::opc_lui: begin
        dec.alu_op = rv_isa_pkg::pass_b;
        dec.use_imm = 1'b1;
        dec.imm = imm_u;
      end
      default: bad = 1'b1;
    endcase
    // illegal encodings pass a zero through and write nothing.
    if (bad) begin
      dec.alu_op = rv_isa_pkg::pass_b;
      dec.use_imm = 1'b1;
      dec.imm = '0;
      dec.writes_rd = 1'b0;
      dec.illegal = 1'b1;
    end
  end

endmodule

/* hw/reg_file.sv */
module reg_file #(
  parameter int num_regs = 32
) (
  input  logic clk,
  input  logic rst,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] rd1_addr,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] rd2_addr,
  output logic [rv_isa_pkg::xlen-1:0] rd1_data,
  output logic [rv_isa_pkg::xlen-1:0] rd2_data,
  input  logic wr_en,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [rv_isa_pkg::xlen-1:0] wr_data
);

  logic [rv_isa_pkg::xlen-1:0] regs [num_regs];
  logic wr_ok;

  // x0 is hardwired, so it never reaches the array.
  assign wr_ok = wr_en && (wr_addr != '0);

  // combinational read ports.
  assign rd1_data = (rd1_addr == '0) ? '0 : regs[rd1_addr];
  assign rd2_data = (rd2_addr == '0) ? '0 : regs[rd2_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= rv_isa_pkg::regs_init;
      end
    end else if (wr_ok) begin
      regs[wr_addr] <= wr_data; // visible to reads from the next cycle.
    end
  end

endmodule

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

  // data path and register index widths.
  localparam int xlen = 64;
  localparam int reg_addr_w = 5;
  localparam int inst_w = 32;
  localparam int shamt_w = 6; // rv64 shifts use six amount bits.

  // every architectural register comes out of reset with this value.
  localparam logic [xlen-1:0] regs_init = '0;

  // funct7 and funct6 patterns that qualify the register and shift encodings.
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt = 7'b0100000; // sub and sra.
  localparam logic [5:0] f6_base = 6'b000000;
  localparam logic [5:0] f6_alt = 6'b010000; // srai.

  // major opcodes handled by the execution subsystem.
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111
  } opcode_e;

  // alu operations.
  typedef enum logic [3:0] {
    add    = 4'd0,
    sub    = 4'd1,
    and_op = 4'd2,
    or_op  = 4'd3,
    xor_op = 4'd4,
    slt    = 4'd5,
    sltu   = 4'd6,
    sll    = 4'd7,
    srl    = 4'd8,
    sra    = 4'd9,
    pass_b = 4'd10 // lui, and the harmless op for illegal encodings.
  } alu_op_e;

endpackage

/* hw/shift_counter.sv */
module shift_counter (
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  logic [rv_isa_pkg::shamt_w-1:0] shamt,
  output logic done
);

  logic [rv_isa_pkg::shamt_w-1:0] count;

  // counts down by one each cycle until it reaches zero.
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      count <= shamt;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign done = (count == '0);

endmodule

/* list.f */
hw/rv_isa_pkg.sv
hw/exec_pkg.sv
hw/reg_file.sv
hw/inst_decoder.sv
hw/execute_unit.sv
hw/shift_counter.sv
hw/exec_ctrl.sv
hw/exec_top.sv
dv/tb_exec_top.sv
